//--- bpu_cfg.svh
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// address and instruction width
`define BPU_XLEN 32

// bimodal table, 64 counters indexed from pc bit 1
`define BPU_BHT_IDX_BITS 6

// btb, 16 entries indexed from pc bit 2, tag is everything above
`define BPU_BTB_IDX_BITS 4

// weakly not taken
`define BPU_CTR_INIT 2'b01

// major opcodes of the control transfer instructions
`define BPU_OP_BRANCH 7'b1100011
`define BPU_OP_JAL    7'b1101111
`define BPU_OP_JALR   7'b1100111

`endif

//--- bpu_pkg.sv
`default_nettype none

`include "bpu_cfg.svh"

package bpu_pkg;

    // b-type layout, immediate split around rs1/rs2
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // j-type layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, both offsets are pulled out of it
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [1:0] {
        CLS_OTHER  = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JAL    = 2'd2,
        CLS_JALR   = 2'd3
    } inst_class_e;

    typedef logic [1:0] ctr_t;  // 2-bit saturating counter

endpackage

`default_nettype wire

//--- bpu_pred_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

// predecode results, valid in the fetch cycle
interface bpu_pred_if;
    import bpu_pkg::*;

    inst_class_e          cls;
    logic [`BPU_XLEN-1:0] br_off;   // sign-extended b-type offset
    logic [`BPU_XLEN-1:0] jal_off;  // sign-extended j-type offset
    logic [`BPU_XLEN-1:0] pc;       // fetch pc passed along

    modport decode (
        output cls,
        output br_off,
        output jal_off,
        output pc
    );

    modport result (
        input cls,
        input br_off,
        input jal_off,
        input pc
    );

endinterface

`default_nettype wire

//--- bpu_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

module bpu_decode (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] if_inst_i,
    input  wire logic [`BPU_XLEN-1:0] if_pc_i,
    bpu_pred_if.decode                pred
);
    import bpu_pkg::*;

    localparam int unsigned BR_SEXT  = `BPU_XLEN - 13;
    localparam int unsigned JAL_SEXT = `BPU_XLEN - 21;

    inst_u inst;

    assign inst = if_inst_i;

    // opcode is shared by both views
    always_comb begin
        case (inst.b_fmt.opcode)
            `BPU_OP_BRANCH: pred.cls = CLS_BRANCH;
            `BPU_OP_JAL:    pred.cls = CLS_JAL;
            `BPU_OP_JALR:   pred.cls = CLS_JALR;
            default:        pred.cls = CLS_OTHER;
        endcase
    end

    // b-type offset, bit 0 implied zero
    assign pred.br_off = {{BR_SEXT{inst.b_fmt.imm12}},
                          inst.b_fmt.imm12,
                          inst.b_fmt.imm11,
                          inst.b_fmt.imm10_5,
                          inst.b_fmt.imm4_1,
                          1'b0};

    // j-type offset from the other view of the same word
    assign pred.jal_off = {{JAL_SEXT{inst.j_fmt.imm20}},
                           inst.j_fmt.imm20,
                           inst.j_fmt.imm19_12,
                           inst.j_fmt.imm11,
                           inst.j_fmt.imm10_1,
                           1'b0};

    assign pred.pc = if_pc_i;

    // fetch side must present a clean word after reset
    cls_known_a: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(inst.b_fmt.opcode));

endmodule

`default_nettype wire

//--- bpu_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

module bpu_execute (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] if_pc_i,
    input  wire logic                 ex_branch_valid_i,
    input  wire logic                 ex_branch_taken_i,
    input  wire logic [`BPU_XLEN-1:0] ex_pc_i,
    input  wire logic [`BPU_XLEN-1:0] ex_target_i,
    output bpu_pkg::ctr_t             dir_ctr_o,
    output logic                      btb_hit_o,
    output logic [`BPU_XLEN-1:0]      btb_target_o
);
    import bpu_pkg::*;

    localparam int unsigned BHT_IDX  = `BPU_BHT_IDX_BITS;
    localparam int unsigned BTB_IDX  = `BPU_BTB_IDX_BITS;
    localparam int unsigned BHT_SIZE = 1 << BHT_IDX;
    localparam int unsigned BTB_SIZE = 1 << BTB_IDX;
    localparam int unsigned TAG_LSB  = BTB_IDX + 2;
    localparam int unsigned TAG_BITS = `BPU_XLEN - TAG_LSB;

    // direction table
    ctr_t bht [BHT_SIZE];

    // btb arrays
    logic [BTB_SIZE-1:0]  btb_valid;
    logic [TAG_BITS-1:0]  btb_tag [BTB_SIZE];
    logic [`BPU_XLEN-1:0] btb_tgt [BTB_SIZE];

    // lookup side
    logic [BHT_IDX-1:0]  rd_bht_idx;
    logic [BTB_IDX-1:0]  rd_btb_idx;
    logic [TAG_BITS-1:0] rd_tag;

    // update side
    logic [BHT_IDX-1:0]  wr_bht_idx;
    logic [BTB_IDX-1:0]  wr_btb_idx;
    logic [TAG_BITS-1:0] wr_tag;
    logic                btb_wr;
    ctr_t                wr_ctr_cur;
    ctr_t                wr_ctr_nxt;

    assign rd_bht_idx = if_pc_i[BHT_IDX:1];
    assign rd_btb_idx = if_pc_i[TAG_LSB-1:2];
    assign rd_tag     = if_pc_i[`BPU_XLEN-1:TAG_LSB];

    assign wr_bht_idx = ex_pc_i[BHT_IDX:1];
    assign wr_btb_idx = ex_pc_i[TAG_LSB-1:2];
    assign wr_tag     = ex_pc_i[`BPU_XLEN-1:TAG_LSB];

    // only taken outcomes allocate a target
    assign btb_wr = ex_branch_valid_i && ex_branch_taken_i;

    // combinational read, old state on a same-cycle update
    assign dir_ctr_o    = bht[rd_bht_idx];
    assign btb_hit_o    = btb_valid[rd_btb_idx] && (btb_tag[rd_btb_idx] == rd_tag);
    assign btb_target_o = btb_tgt[rd_btb_idx];

    // step the counter toward the outcome
    always_comb begin
        wr_ctr_cur = bht[wr_bht_idx];
        wr_ctr_nxt = wr_ctr_cur;
        if (ex_branch_taken_i) begin
            if (wr_ctr_cur != 2'b11) begin
                wr_ctr_nxt = wr_ctr_cur + 2'b01;
            end
        end else begin
            if (wr_ctr_cur != 2'b00) begin
                wr_ctr_nxt = wr_ctr_cur - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BHT_SIZE; i++) begin
                bht[i] <= `BPU_CTR_INIT;  // weakly not taken
            end
        end else if (ex_branch_valid_i) begin
            bht[wr_bht_idx] <= wr_ctr_nxt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btb_valid <= '0;  // all entries empty
        end else if (btb_wr) begin
            btb_valid[wr_btb_idx] <= 1'b1;
        end
    end

    // tag and target of a taken update
    always_ff @(posedge clk) begin
        if (btb_wr) begin
            btb_tag[wr_btb_idx] <= wr_tag;
            btb_tgt[wr_btb_idx] <= ex_target_i;
        end
    end

    // execute stage must hand over a clean update
    upd_known_a: assert property (@(posedge clk) disable iff (rst)
        ex_branch_valid_i |-> !$isunknown({ex_branch_taken_i, ex_pc_i, ex_target_i}));

    // strongly taken stays there after another taken outcome
    ctr_sat_a: assert property (@(posedge clk) disable iff (rst)
        (ex_branch_valid_i && ex_branch_taken_i && wr_ctr_cur == 2'b11)
        |=> bht[$past(wr_bht_idx)] == 2'b11);

endmodule

`default_nettype wire

//--- bpu_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

module bpu_result (
    input  wire logic                 clk,
    input  wire logic                 rst,
    bpu_pred_if.result                pred,
    input  wire bpu_pkg::ctr_t        dir_ctr_i,
    input  wire logic                 btb_hit_i,
    input  wire logic [`BPU_XLEN-1:0] btb_target_i,
    output logic                      branch_o,
    output logic                      pdt_taken_o,
    output logic [`BPU_XLEN-1:0]      pdt_pc_o
);
    import bpu_pkg::*;

    localparam logic [`BPU_XLEN-1:0] INST_BYTES = 4;

    logic [`BPU_XLEN-1:0] own_off;

    assign branch_o = (pred.cls != CLS_OTHER);

    // direction
    always_comb begin
        case (pred.cls)
            CLS_BRANCH: pdt_taken_o = dir_ctr_i[1];  // upper counter bit
            CLS_JAL:    pdt_taken_o = 1'b1;
            default:    pdt_taken_o = 1'b0;          // jalr has no target source
        endcase
    end

    // fallback target when the btb misses
    assign own_off = (pred.cls == CLS_JAL) ? pred.jal_off : pred.br_off;

    // next fetch pc
    always_comb begin
        if (!pdt_taken_o) begin
            pdt_pc_o = pred.pc + INST_BYTES;
        end else if (btb_hit_i) begin
            pdt_pc_o = btb_target_i;  // btb wins over the decoded offset
        end else begin
            pdt_pc_o = pred.pc + own_off;
        end
    end

    // execute must return a known lookup for a control word
    lookup_known_a: assert property (@(posedge clk) disable iff (rst)
        branch_o |-> !$isunknown({dir_ctr_i, btb_hit_i}));

endmodule

`default_nettype wire

//--- bpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

module bpu_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] if_pc_i,
    input  wire logic [`BPU_XLEN-1:0] if_inst_i,
    input  wire logic                 ex_branch_valid_i,
    input  wire logic                 ex_branch_taken_i,
    input  wire logic [`BPU_XLEN-1:0] ex_pc_i,
    input  wire logic [`BPU_XLEN-1:0] ex_target_i,
    output logic                      branch_o,
    output logic                      pdt_taken_o,
    output logic [`BPU_XLEN-1:0]      pdt_pc_o
);
    import bpu_pkg::*;

    bpu_pred_if pred_if ();

    // execute to result
    ctr_t                 dir_ctr;
    logic                 btb_hit;
    logic [`BPU_XLEN-1:0] btb_target;

    bpu_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .if_inst_i (if_inst_i),
        .if_pc_i   (if_pc_i),
        .pred      (pred_if.decode)
    );

    bpu_execute u_execute (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .dir_ctr_o         (dir_ctr),
        .btb_hit_o         (btb_hit),
        .btb_target_o      (btb_target)
    );

    bpu_result u_result (
        .clk          (clk),
        .rst          (rst),
        .pred         (pred_if.result),
        .dir_ctr_i    (dir_ctr),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .branch_o     (branch_o),
        .pdt_taken_o  (pdt_taken_o),
        .pdt_pc_o     (pdt_pc_o)
    );

endmodule

`default_nettype wire

//--- tb_bpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpu_cfg.svh"

module tb_bpu;

    localparam int BHT_IDX = `BPU_BHT_IDX_BITS;
    localparam int BTB_IDX = `BPU_BTB_IDX_BITS;
    localparam int TAG_LSB = BTB_IDX + 2;
    localparam logic [`BPU_XLEN-1:0] TRAIN_PC = 32'h0000_1040;

    logic                 clk;
    logic                 rst;
    logic [`BPU_XLEN-1:0] if_pc_i;
    logic [`BPU_XLEN-1:0] if_inst_i;
    logic                 ex_branch_valid_i;
    logic                 ex_branch_taken_i;
    logic [`BPU_XLEN-1:0] ex_pc_i;
    logic [`BPU_XLEN-1:0] ex_target_i;
    logic                 branch_o;
    logic                 pdt_taken_o;
    logic [`BPU_XLEN-1:0] pdt_pc_o;

    logic [31:0] lfsr_state;
    logic [31:0] train_inst;  // branch word used at TRAIN_PC

    // reference model state
    logic [1:0]           shadow_ctr   [1 << BHT_IDX];
    logic                 shadow_valid [1 << BTB_IDX];
    logic [`BPU_XLEN-1:0] shadow_tag   [1 << BTB_IDX];
    logic [`BPU_XLEN-1:0] shadow_tgt   [1 << BTB_IDX];

    bpu_top uut (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .if_inst_i         (if_inst_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .branch_o          (branch_o),
        .pdt_taken_o       (pdt_taken_o),
        .pdt_pc_o          (pdt_pc_o)
    );

    always #50 clk = ~clk;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    // overall cycle limit
    initial begin
        repeat (5000) @(posedge clk);
        abort_run("simulation ran past its cycle limit");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = lfsr_bits(30);
        return {r[29:0], 2'b00};
    endfunction

    function automatic logic [31:0] branch_word(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], `BPU_OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `BPU_OP_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd0, `BPU_OP_JALR};
    endfunction

    // offsets straight from the isa bit positions
    function automatic logic [31:0] branch_offset(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] jump_offset(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < (1 << BHT_IDX); i++) begin
            shadow_ctr[i] = `BPU_CTR_INIT;
        end
        for (int i = 0; i < (1 << BTB_IDX); i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
            shadow_tgt[i]   = '0;
        end
    endfunction

    function automatic void update_model(input logic [31:0] pc, input logic taken,
                                         input logic [31:0] tgt);
        if (taken && shadow_ctr[pc[BHT_IDX:1]] != 2'b11) begin
            shadow_ctr[pc[BHT_IDX:1]] = shadow_ctr[pc[BHT_IDX:1]] + 2'd1;
        end else if (!taken && shadow_ctr[pc[BHT_IDX:1]] != 2'b00) begin
            shadow_ctr[pc[BHT_IDX:1]] = shadow_ctr[pc[BHT_IDX:1]] - 2'd1;
        end
        if (taken) begin
            shadow_valid[pc[TAG_LSB-1:2]] = 1'b1;
            shadow_tag[pc[TAG_LSB-1:2]]   = pc >> TAG_LSB;
            shadow_tgt[pc[TAG_LSB-1:2]]   = tgt;
        end
    endfunction

    function automatic void predict_expected(input logic [31:0] pc, input logic [31:0] inst,
                                             output logic br, output logic tk,
                                             output logic [31:0] npc);
        logic hit;
        br  = (inst[6:0] == `BPU_OP_BRANCH) || (inst[6:0] == `BPU_OP_JAL) ||
              (inst[6:0] == `BPU_OP_JALR);
        tk  = (inst[6:0] == `BPU_OP_JAL) ||
              ((inst[6:0] == `BPU_OP_BRANCH) && shadow_ctr[pc[BHT_IDX:1]][1]);
        hit = shadow_valid[pc[TAG_LSB-1:2]] && (shadow_tag[pc[TAG_LSB-1:2]] == (pc >> TAG_LSB));
        if (!tk) begin
            npc = pc + 32'd4;
        end else if (hit) begin
            npc = shadow_tgt[pc[TAG_LSB-1:2]];
        end else if (inst[6:0] == `BPU_OP_JAL) begin
            npc = pc + jump_offset(inst);
        end else begin
            npc = pc + branch_offset(inst);
        end
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_run("reset was not released within 20 cycles");
            end
        end
    endtask

    // outputs are combinational, sampled well before the next edge
    task automatic lookup_and_compare(input logic [31:0] pc, input logic [31:0] inst);
        logic        exp_br;
        logic        exp_tk;
        logic [31:0] exp_pc;
        @(negedge clk);
        if_pc_i   = pc;
        if_inst_i = inst;
        #10;
        predict_expected(pc, inst, exp_br, exp_tk, exp_pc);
        check("branch_o", 32'(branch_o), 32'(exp_br));
        check("pdt_taken_o", 32'(pdt_taken_o), 32'(exp_tk));
        check("pdt_pc_o", pdt_pc_o, exp_pc);
    endtask

    task automatic send_update(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
        @(negedge clk);
        ex_branch_valid_i = 1'b1;
        ex_branch_taken_i = taken;
        ex_pc_i           = pc;
        ex_target_i       = tgt;
        update_model(pc, taken, tgt);
        @(negedge clk);
        ex_branch_valid_i = 1'b0;
    endtask

    task automatic non_control_words();
        logic [31:0] pc;
        logic [31:0] word;
        for (int i = 0; i < 8; i++) begin
            pc      = random_pc();
            word    = lfsr_bits(32);
            word[0] = 1'b0;  // no control opcode ends in 0
            lookup_and_compare(pc, word);
            check("pdt_pc_o", pdt_pc_o, pc + 32'd4);
        end
    endtask

    task automatic jal_and_jalr();
        logic [31:0] pc;
        logic [31:0] r;
        logic [31:0] off;
        pc  = random_pc();
        r   = lfsr_bits(20);
        off = {{11{r[19]}}, r[19:0], 1'b0};
        lookup_and_compare(pc, jal_word(off));
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd1);
        check("pdt_pc_o", pdt_pc_o, pc + off);
        pc = random_pc();
        r  = lfsr_bits(12);
        lookup_and_compare(pc, jalr_word(r[11:0]));
        check("branch_o", 32'(branch_o), 32'd1);
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd0);
    endtask

    task automatic fresh_branch();
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] tgt;
        r          = lfsr_bits(12);
        off        = {{19{r[11]}}, r[11:0], 1'b0};
        train_inst = branch_word(off);
        lookup_and_compare(TRAIN_PC, train_inst);
        check("pdt_pc_o", pdt_pc_o, TRAIN_PC + 32'd4);
        tgt = TRAIN_PC + off + 32'h100;  // away from the decoded target
        send_update(TRAIN_PC, 1'b1, tgt);
        lookup_and_compare(TRAIN_PC, train_inst);
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd1);
        check("pdt_pc_o", pdt_pc_o, tgt);
    endtask

    task automatic counter_saturation();
        repeat (3) send_update(TRAIN_PC, 1'b1, TRAIN_PC + 32'h200);
        send_update(TRAIN_PC, 1'b0, 32'h0);
        lookup_and_compare(TRAIN_PC, train_inst);
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd1);
        send_update(TRAIN_PC, 1'b0, 32'h0);
        lookup_and_compare(TRAIN_PC, train_inst);
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd0);
        check("pdt_pc_o", pdt_pc_o, TRAIN_PC + 32'd4);
    endtask

    task automatic btb_alias();
        logic [31:0] alias_pc;
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] tgt;
        alias_pc = TRAIN_PC ^ 32'h40;  // same btb slot, other tag and counter
        r        = lfsr_bits(12);
        off      = {{19{r[11]}}, r[11:0], 1'b0};
        send_update(alias_pc, 1'b1, 32'h0000_8000);
        tgt = 32'h0000_9000;
        send_update(TRAIN_PC, 1'b1, tgt);  // slot goes back to TRAIN_PC
        lookup_and_compare(alias_pc, branch_word(off));
        check("pdt_taken_o", 32'(pdt_taken_o), 32'd1);
        check("pdt_pc_o", pdt_pc_o, alias_pc + off);
        lookup_and_compare(TRAIN_PC, jal_word(32'h0000_0010));
        check("pdt_pc_o", pdt_pc_o, tgt);
    endtask

    task automatic random_sequence();
        logic [31:0] pcs [4];
        logic [31:0] r;
        logic [31:0] t;
        logic [31:0] tgt;
        pcs[0] = 32'h0000_2000;
        pcs[1] = 32'h0000_2040;  // shares the btb slot of pcs[0]
        pcs[2] = 32'h0000_2080;  // shares slot and counter of pcs[0]
        pcs[3] = 32'h0000_2014;
        for (int n = 0; n < 24; n++) begin
            r   = lfsr_bits(2);
            t   = lfsr_bits(1);
            tgt = random_pc();
            send_update(pcs[r[1:0]], t[0], tgt);
            for (int k = 0; k < 4; k++) begin
                lookup_and_compare(pcs[k], branch_word(32'h0000_0020));
            end
            lookup_and_compare(pcs[r[1:0]], jal_word(32'h0000_0400));
        end
    endtask

    initial begin
        if_pc_i           = '0;
        if_inst_i         = '0;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pc_i           = '0;
        ex_target_i       = '0;
        lfsr_state        = 32'he70f;
        train_inst        = '0;
        reset_model();
        wait_reset_release();
        non_control_words();
        jal_and_jalr();
        fresh_branch();
        counter_saturation();
        btb_alias();
        random_sequence();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bpu_pkg.sv
bpu_pred_if.sv
bpu_decode.sv
bpu_execute.sv
bpu_result.sv
bpu_top.sv
tb_bpu.sv

//--- run.sh
#!/bin/sh
# compile and run the bpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bpu -f project.f -o tb_bpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

# a failing check ends the run through $fatal, giving a nonzero status
./obj_dir/tb_bpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation passed"
exit 0
